// ==== flist.f ====
hdl/raster_mem_pkg.sv
hdl/raster_fetch_ctrl.sv
hdl/raster_prim_addr.sv
hdl/raster_rs.sv
hdl/raster_mem.sv
test/raster_mem_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the raster_mem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module raster_mem_tb -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vraster_mem_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "No errors"; then
    exit 0
fi
exit 1

// ==== test/raster_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module raster_mem_tb;
    localparam int SLICE_NUM   = 4;
    localparam int TILE_SIZE   = 16;
    localparam int RS_SIZE     = 8;
    localparam int SLICE_BITS  = (SLICE_NUM > 1) ? $clog2(SLICE_NUM) : 1;
    localparam int TILE_SHIFT  = $clog2(TILE_SIZE);
    localparam int DIM         = raster_mem_pkg::DIM_BITS;
    localparam int NL          = raster_mem_pkg::NUM_LANES;
    // Primitives per test, in test order
    localparam int TOTAL_PRIMS = 1 + 6 + 12 + 8 + 3;
    localparam int PRIM_CYCLES = 40;
    localparam int MARGIN      = 1500;

    logic                           clk;
    logic                           reset;
    logic                           start;
    raster_mem_pkg::raster_cfg_t    cfg;
    logic                           busy;
    raster_mem_pkg::mem_req_t       mem_req;
    raster_mem_pkg::mem_rsp_t       mem_rsp;
    logic [SLICE_NUM-1:0]           slice_ready;
    logic                           out_valid;
    raster_mem_pkg::raster_packet_t out_packet;
    logic [SLICE_BITS-1:0]          out_slice;

    integer seed = 32'hf90a_b8e2;
    logic [31:0] mem_words [logic [31:0]];
    raster_mem_pkg::raster_packet_t exp_pkts [logic [31:0]];
    raster_mem_pkg::mem_req_t req_log [$];
    int          tile_prims [$];
    int          errors, err_at_start, tests_run;
    int          req_cnt, id_req_cnt, data_rsp_cnt, out_cnt;
    logic [31:0] next_pid;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    raster_mem #(
        .SLICE_NUM (SLICE_NUM),
        .TILE_SIZE (TILE_SIZE),
        .RS_SIZE   (RS_SIZE)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .cfg         (cfg),
        .busy        (busy),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .slice_ready (slice_ready),
        .out_valid   (out_valid),
        .out_packet  (out_packet),
        .out_slice   (out_slice)
    );

    // Unwritten words read back as the inverted address
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        return ~addr;
    endfunction

    function automatic logic [SLICE_BITS-1:0] first_ready(input logic [SLICE_NUM-1:0] ready);
        logic [SLICE_BITS-1:0] idx;
        logic                  found;
        idx   = '0;
        found = 1'b0;
        for (int i = 0; i < SLICE_NUM; i++) begin
            if (ready[i] && !found) begin
                idx   = SLICE_BITS'(i);
                found = 1'b1;
            end
        end
        return idx;
    endfunction

    function automatic raster_mem_pkg::raster_cfg_t make_cfg(input logic [31:0] tiles,
            input logic [31:0] tbase, input logic [31:0] pbase, input logic [31:0] stride);
        raster_mem_pkg::raster_cfg_t c;
        c.num_tiles   = tiles;
        c.tbuf_base   = tbase;
        c.pbuf_base   = pbase;
        c.pbuf_stride = stride;
        return c;
    endfunction

    task automatic check_packet(input string name, input raster_mem_pkg::raster_packet_t got,
                                input raster_mem_pkg::raster_packet_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_req(input string name, input raster_mem_pkg::mem_req_t got,
                             input raster_mem_pkg::mem_req_t exp);
        raster_mem_pkg::mem_req_t seen;
        seen = got;
        // Addresses of disabled lanes carry no meaning
        for (int i = 0; i < NL; i++) begin
            if (!exp.mask[i]) begin
                seen.addr[i] = '0;
            end
        end
        if (seen !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, seen, exp);
        end
    endtask

    task automatic check_slice(input string name, input logic [SLICE_BITS-1:0] got,
                               input logic [SLICE_BITS-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Responds to each request after 1 to 6 cycles
    initial begin : memory_model
        raster_mem_pkg::mem_req_t req;
        raster_mem_pkg::mem_rsp_t rsp;
        int                       delay;
        mem_rsp = '0;
        forever begin
            @(posedge clk);
            if (mem_req.valid === 1'b1) begin
                req = mem_req;
                req_log.push_back(req);
                req_cnt++;
                if (req.kind == raster_mem_pkg::PRIM_ID_FETCH) begin
                    id_req_cnt++;
                end
                delay = 1 + int'((32'($random(seed)) & 32'h7fff_ffff) % 32'd6);
                repeat (delay - 1) @(posedge clk);
                rsp       = '0;
                rsp.valid = 1'b1;
                rsp.kind  = req.kind;
                for (int i = 0; i < NL; i++) begin
                    if (req.mask[i]) begin
                        rsp.data[i] = read_word(req.addr[i]);
                    end
                end
                if (req.kind == raster_mem_pkg::PRIM_DATA_FETCH) begin
                    data_rsp_cnt++;
                end
                mem_rsp <= rsp;
                @(posedge clk);
                mem_rsp.valid <= 1'b0;
            end
        end
    end

    // Slice side: packet lookup by pid, slice choice and dispatch spacing
    always @(posedge clk) begin : slice_monitor
        logic                 prev_valid;
        logic [SLICE_NUM-1:0] prev_ready;
        if (out_valid === 1'b1) begin
            out_cnt++;
            if (prev_valid) begin
                errors++;
                $display("Dispatches in two adjacent cycles");
            end
            check_slice("out_slice", out_slice, first_ready(prev_ready));
            if (exp_pkts.exists(out_packet.pid)) begin
                check_packet("out_packet", out_packet, exp_pkts[out_packet.pid]);
                exp_pkts.delete(out_packet.pid);
            end else begin
                errors++;
                $display("Packet with unexpected or repeated pid %h", out_packet.pid);
            end
        end
        prev_valid = (out_valid === 1'b1);
        prev_ready = slice_ready;
    end

    // Writes tile records and primitive edges, and records the packets they should yield
    task automatic build_job(input raster_mem_pkg::raster_cfg_t c);
        logic [31:0] addr, pid, ea, col, row;
        raster_mem_pkg::raster_packet_t p;
        addr = c.tbuf_base;
        foreach (tile_prims[t]) begin
            col = 32'($random(seed)) & 32'hff;
            row = 32'($random(seed)) & 32'hff;
            mem_words[addr] = {row[15:0], col[15:0]};
            mem_words[addr + 32'd4] = 32'(tile_prims[t]);
            addr = addr + 32'd8;
            for (int k = 0; k < tile_prims[t]; k++) begin
                pid = next_pid;
                next_pid = next_pid + 32'd3;
                mem_words[addr] = pid;
                addr = addr + 32'd4;
                p.x_loc = DIM'(col << TILE_SHIFT);
                p.y_loc = DIM'(row << TILE_SHIFT);
                p.pid   = pid;
                for (int i = 0; i < NL; i++) begin
                    ea = c.pbuf_base + pid * c.pbuf_stride + 32'(4 * i);
                    mem_words[ea] = 32'($random(seed));
                    p.edges[i / 3][i % 3] = mem_words[ea];
                end
                exp_pkts[pid] = p;
            end
        end
    endtask

    task automatic pulse_start(input raster_mem_pkg::raster_cfg_t c);
        @(posedge clk);
        cfg   <= c;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic finish_job(input int target);
        int waited;
        int limit;
        waited = 0;
        limit  = 60 * target + 100;
        @(posedge clk);
        while ((busy === 1'b1 || out_cnt < target) && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        repeat (4) @(posedge clk);
        if (waited >= limit) begin
            errors++;
            $display("Job did not complete, busy %b with %0d of %0d packets", busy, out_cnt, target);
        end
        if (exp_pkts.size() != 0) begin
            errors++;
            $display("%0d expected packets never arrived", exp_pkts.size());
        end
        if (out_cnt != target) begin
            errors++;
            $display("CHECK FAILED out_valid pulses: got %h expected %h", out_cnt, target);
        end
    endtask

    task automatic begin_test();
        req_log.delete();
        exp_pkts.delete();
        req_cnt      = 0;
        id_req_cnt   = 0;
        data_rsp_cnt = 0;
        out_cnt      = 0;
        err_at_start = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("%-14s %s, %0d errors", name, (errors == err_at_start) ? "passed" : "failed",
                 errors - err_at_start);
    endtask

    task automatic test_single();
        raster_mem_pkg::raster_cfg_t c;
        raster_mem_pkg::mem_req_t    exp;
        logic [31:0]                 pid;
        begin_test();
        slice_ready <= '1;
        tile_prims = '{1};
        c   = make_cfg(32'd1, 32'h1000, 32'h0010_0000, 32'd36);
        pid = next_pid;
        build_job(c);
        pulse_start(c);
        @(posedge clk);
        if (busy !== 1'b1) begin
            errors++;
            $display("busy did not rise after start");
        end
        finish_job(1);
        if (req_log.size() != 3) begin
            errors++;
            $display("Expected 3 memory requests but saw %0d", req_log.size());
        end else begin
            exp         = '0;
            exp.valid   = 1'b1;
            exp.kind    = raster_mem_pkg::TILE_FETCH;
            exp.mask    = raster_mem_pkg::TILE_MASK;
            exp.addr[0] = c.tbuf_base;
            exp.addr[1] = c.tbuf_base + 32'd4;
            check_req("tile request", req_log[0], exp);
            exp         = '0;
            exp.valid   = 1'b1;
            exp.kind    = raster_mem_pkg::PRIM_ID_FETCH;
            exp.mask    = raster_mem_pkg::PRIM_ID_MASK;
            exp.addr[0] = c.tbuf_base + 32'd8;
            check_req("id request", req_log[1], exp);
            exp       = '0;
            exp.valid = 1'b1;
            exp.kind  = raster_mem_pkg::PRIM_DATA_FETCH;
            exp.mask  = raster_mem_pkg::PRIM_DATA_MASK;
            for (int i = 0; i < NL; i++) begin
                exp.addr[i] = c.pbuf_base + pid * c.pbuf_stride + 32'(4 * i);
            end
            check_req("data request", req_log[2], exp);
        end
        end_test("single");
    endtask

    task automatic test_multi();
        raster_mem_pkg::raster_cfg_t c;
        begin_test();
        slice_ready <= '1;
        tile_prims = '{2, 1, 3};
        c = make_cfg(32'd3, 32'h2000, 32'h0020_0000, 32'd52);
        build_job(c);
        pulse_start(c);
        finish_job(6);
        end_test("multi_tile");
    endtask

    task automatic test_backpressure();
        raster_mem_pkg::raster_cfg_t c;
        int                          waited;
        begin_test();
        slice_ready <= '0;
        tile_prims = '{12};
        c = make_cfg(32'd1, 32'h3000, 32'h0030_0000, 32'd40);
        build_job(c);
        pulse_start(c);
        waited = 0;
        while (data_rsp_cnt < RS_SIZE && waited < 400) begin
            @(posedge clk);
            waited++;
        end
        // Station is full now and must stay that way
        repeat (40) @(posedge clk);
        if (data_rsp_cnt != RS_SIZE || id_req_cnt != RS_SIZE || out_cnt != 0) begin
            errors++;
            $display("Station full but %0d id requests and %0d data responses, expected %0d",
                     id_req_cnt, data_rsp_cnt, RS_SIZE);
        end
        slice_ready <= '1;
        finish_job(12);
        end_test("backpressure");
    endtask

    task automatic test_slices();
        raster_mem_pkg::raster_cfg_t c;
        logic [SLICE_NUM-1:0]        patterns [2];
        begin_test();
        patterns[0] = 4'b0100;
        patterns[1] = 4'b1010;
        for (int j = 0; j < 2; j++) begin
            slice_ready <= patterns[j];
            tile_prims = '{4};
            c = make_cfg(32'd1, 32'h4000 + 32'(j * 256), 32'h0040_0000, 32'd48);
            build_job(c);
            pulse_start(c);
            finish_job(4 * (j + 1));
        end
        end_test("slice_select");
    endtask

    task automatic test_ignored();
        raster_mem_pkg::raster_cfg_t c;
        begin_test();
        slice_ready <= '1;
        pulse_start(make_cfg(32'd0, 32'h5000, 32'h0050_0000, 32'd44));
        repeat (10) @(posedge clk);
        if (req_cnt != 0 || busy !== 1'b0) begin
            errors++;
            $display("Start with zero tiles was not ignored");
        end
        tile_prims = '{3};
        c = make_cfg(32'd1, 32'h5100, 32'h0050_0000, 32'd44);
        build_job(c);
        pulse_start(c);
        // Second start lands while the first job runs
        pulse_start(make_cfg(32'd2, 32'h5800, 32'h0058_0000, 32'd48));
        finish_job(3);
        if (req_cnt != 7) begin
            errors++;
            $display("Expected 7 memory requests but saw %0d", req_cnt);
        end
        end_test("ignored_start");
    endtask

    initial begin : watchdog
        repeat (16 + TOTAL_PRIMS * PRIM_CYCLES + MARGIN) @(posedge clk);
        $display("Timeout, the tests did not finish within the cycle limit");
        $display("Errors found");
        $finish;
    end

    initial begin : main
        reset       = 1'b1;
        start       = 1'b0;
        cfg         = '0;
        slice_ready = '0;
        errors      = 0;
        tests_run   = 0;
        next_pid    = 32'd5;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        test_single();
        test_multi();
        test_backpressure();
        test_slices();
        test_ignored();
        $display("Tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/raster_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module raster_mem #(
    parameter int SLICE_NUM = 4,
    parameter int TILE_SIZE = 16,
    parameter int RS_SIZE   = 8
) (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic                           start,
    input  wire raster_mem_pkg::raster_cfg_t    cfg,
    output logic                                busy,
    output raster_mem_pkg::mem_req_t            mem_req,
    input  wire raster_mem_pkg::mem_rsp_t       mem_rsp,
    input  wire logic [SLICE_NUM-1:0]           slice_ready,
    output logic                                out_valid,
    output raster_mem_pkg::raster_packet_t      out_packet,
    output logic [((SLICE_NUM > 1) ? $clog2(SLICE_NUM) : 1)-1:0] out_slice
);
    localparam int DW = raster_mem_pkg::DATA_BITS;

    logic                  pid_valid;
    logic [DW-1:0]         pid;
    logic                  addr_valid;
    logic [raster_mem_pkg::NUM_LANES-1:0][DW-1:0] edge_addr;
    logic                  rs_write;
    logic                  rs_free;
    logic [DW-1:0]         pbuf_base_q, pbuf_stride_q;
    raster_mem_pkg::raster_packet_t rs_packet;

    // Primitive buffer geometry is held for the whole job
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            pbuf_base_q   <= cfg.pbuf_base;
            pbuf_stride_q <= cfg.pbuf_stride;
        end
    end

    raster_fetch_ctrl #(
        .TILE_SIZE (TILE_SIZE)
    ) fetch_ctrl0 (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .cfg        (cfg),
        .mem_rsp    (mem_rsp),
        .rs_free    (rs_free),
        .addr_valid (addr_valid),
        .edge_addr  (edge_addr),
        .mem_req    (mem_req),
        .pid_valid  (pid_valid),
        .pid        (pid),
        .rs_write   (rs_write),
        .rs_packet  (rs_packet),
        .busy       (busy)
    );

    raster_prim_addr prim_addr0 (
        .clk         (clk),
        .reset       (reset),
        .pid_valid   (pid_valid),
        .pid         (pid),
        .pbuf_base   (pbuf_base_q),
        .pbuf_stride (pbuf_stride_q),
        .addr_valid  (addr_valid),
        .edge_addr   (edge_addr)
    );

    raster_rs #(
        .RS_SIZE   (RS_SIZE),
        .SLICE_NUM (SLICE_NUM)
    ) rs0 (
        .clk         (clk),
        .reset       (reset),
        .rs_write    (rs_write),
        .rs_packet   (rs_packet),
        .slice_ready (slice_ready),
        .rs_free     (rs_free),
        .out_valid   (out_valid),
        .out_packet  (out_packet),
        .out_slice   (out_slice)
    );

endmodule

`default_nettype wire

// ==== hdl/raster_rs.sv ====
`timescale 1ns/1ps
`default_nettype none

module raster_rs #(
    parameter int RS_SIZE   = 8,
    parameter int SLICE_NUM = 4
) (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic                           rs_write,
    input  wire raster_mem_pkg::raster_packet_t rs_packet,
    input  wire logic [SLICE_NUM-1:0]           slice_ready,
    output logic                                rs_free,
    output logic                                out_valid,
    output raster_mem_pkg::raster_packet_t      out_packet,
    output logic [((SLICE_NUM > 1) ? $clog2(SLICE_NUM) : 1)-1:0] out_slice
);
    localparam int RS_BITS    = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1;
    localparam int SLICE_BITS = (SLICE_NUM > 1) ? $clog2(SLICE_NUM) : 1;
    localparam int ENC_W      = (RS_SIZE > SLICE_NUM) ? RS_SIZE : SLICE_NUM;
    localparam int ENC_BITS   = (ENC_W > 1) ? $clog2(ENC_W) : 1;

    raster_mem_pkg::raster_packet_t slot_q [RS_SIZE];
    logic [RS_SIZE-1:0]    slot_valid;
    logic [RS_SIZE-1:0]    wr_mask;
    logic [RS_BITS-1:0]    free_idx, disp_idx;
    logic [SLICE_BITS-1:0] ready_idx;
    logic                  dispatch;

    // Index of the lowest set bit, zero when none is set
    function automatic logic [ENC_BITS-1:0] lowest_set(input logic [ENC_W-1:0] vec);
        logic [ENC_BITS-1:0] idx;
        idx = '0;
        for (int i = ENC_W - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = ENC_BITS'(i);
            end
        end
        return idx;
    endfunction

    assign free_idx  = RS_BITS'(lowest_set(ENC_W'(~slot_valid)));
    assign disp_idx  = RS_BITS'(lowest_set(ENC_W'(slot_valid)));
    assign ready_idx = SLICE_BITS'(lowest_set(ENC_W'(slice_ready)));

    // A slot taken by this cycle's write no longer counts as free
    always_comb begin
        wr_mask = '0;
        if (rs_write) begin
            wr_mask[free_idx] = 1'b1;
        end
    end
    assign rs_free = |(~slot_valid & ~wr_mask);

    // At most one dispatch every other cycle
    assign dispatch = (|slot_valid) && (|slice_ready) && !out_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_valid <= '0;
            out_valid  <= 1'b0;
        end else begin
            out_valid <= dispatch;
            if (rs_write) begin
                slot_valid[free_idx] <= 1'b1;
            end
            // Dispatch only touches a valid slot, never the one being written
            if (dispatch) begin
                slot_valid[disp_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rs_write) begin
            slot_q[free_idx] <= rs_packet;
        end
        if (dispatch) begin
            out_packet <= slot_q[disp_idx];
            out_slice  <= ready_idx;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/raster_prim_addr.sv ====
`timescale 1ns/1ps
`default_nettype none

module raster_prim_addr (
    input  wire logic                                 clk,
    input  wire logic                                 reset,
    input  wire logic                                 pid_valid,
    input  wire logic [raster_mem_pkg::DATA_BITS-1:0] pid,
    input  wire logic [raster_mem_pkg::DATA_BITS-1:0] pbuf_base,
    input  wire logic [raster_mem_pkg::DATA_BITS-1:0] pbuf_stride,
    output logic                                      addr_valid,
    output logic [raster_mem_pkg::NUM_LANES-1:0][raster_mem_pkg::DATA_BITS-1:0] edge_addr
);
    localparam int DW  = raster_mem_pkg::DATA_BITS;
    localparam int LAT = raster_mem_pkg::PRIM_ADDR_LATENCY;

    logic [LAT-1:0] valid_sr;
    logic [DW-1:0]  prod_q;
    logic [DW-1:0]  prim_base_q;

    // Valid bit travels alongside the three data stages
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[LAT-2:0], pid_valid};
        end
    end

    // Stage 1 multiply, stage 2 base add, stage 3 per-lane offsets
    always_ff @(posedge clk) begin
        prod_q      <= pid * pbuf_stride;
        prim_base_q <= pbuf_base + prod_q;
        for (int i = 0; i < raster_mem_pkg::NUM_LANES; i++) begin
            edge_addr[i] <= prim_base_q + DW'(raster_mem_pkg::WORD_BYTES * i);
        end
    end

    assign addr_valid = valid_sr[LAT-1];

endmodule

`default_nettype wire

// ==== hdl/raster_fetch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module raster_fetch_ctrl #(
    parameter int TILE_SIZE = 16
) (
    input  wire logic                             clk,
    input  wire logic                             reset,
    input  wire logic                             start,
    input  wire raster_mem_pkg::raster_cfg_t      cfg,
    input  wire raster_mem_pkg::mem_rsp_t         mem_rsp,
    input  wire logic                             rs_free,
    input  wire logic                             addr_valid,
    input  wire logic [raster_mem_pkg::NUM_LANES-1:0][raster_mem_pkg::DATA_BITS-1:0] edge_addr,
    output raster_mem_pkg::mem_req_t              mem_req,
    output logic                                  pid_valid,
    output logic [raster_mem_pkg::DATA_BITS-1:0]  pid,
    output logic                                  rs_write,
    output raster_mem_pkg::raster_packet_t        rs_packet,
    output logic                                  busy
);
    localparam int TILE_BITS = $clog2(TILE_SIZE);
    localparam int DW        = raster_mem_pkg::DATA_BITS;
    localparam int DIM       = raster_mem_pkg::DIM_BITS;

    logic [DW-1:0]  num_tiles_q, tile_count, prim_count, num_prims;
    logic [DW-1:0]  tbuf_ptr, ptr_next, tile_base;
    logic [DIM-1:0] x_loc_q, y_loc_q;
    logic [DW-1:0]  pid_q;
    logic           id_pending;
    logic           start_ok, rsp_tile, rsp_id, rsp_data;
    logic           last_prim, last_tile, want_id;
    raster_mem_pkg::tile_word_u lane0;
    raster_mem_pkg::mem_req_t   req_next;

    assign lane0.raw = mem_rsp.data[0];

    assign start_ok  = start && !busy && (cfg.num_tiles != '0);
    assign rsp_tile  = busy && mem_rsp.valid && (mem_rsp.kind == raster_mem_pkg::TILE_FETCH);
    assign rsp_id    = busy && mem_rsp.valid && (mem_rsp.kind == raster_mem_pkg::PRIM_ID_FETCH);
    assign rsp_data  = busy && mem_rsp.valid && (mem_rsp.kind == raster_mem_pkg::PRIM_DATA_FETCH);
    assign last_prim = (prim_count + 1'b1) == num_prims;
    assign last_tile = (tile_count + 1'b1) == num_tiles_q;

    // An id fetch is owed after a tile, after a non-final primitive, or while stalled
    assign want_id = id_pending || rsp_tile || (rsp_data && !last_prim);

    // The id goes straight into the address pipeline
    assign pid_valid = rsp_id;
    assign pid       = lane0.raw;

    // Packet is written into the station while the data response is on the bus
    assign rs_write = rsp_data;
    always_comb begin
        rs_packet.x_loc = x_loc_q;
        rs_packet.y_loc = y_loc_q;
        rs_packet.pid   = pid_q;
        for (int i = 0; i < raster_mem_pkg::NUM_LANES; i++) begin
            rs_packet.edges[i / 3][i % 3] = raster_mem_pkg::edge_word_t'(mem_rsp.data[i]);
        end
    end

    // Next request; at most one source is active in any cycle
    always_comb begin
        tile_base     = start_ok ? cfg.tbuf_base : tbuf_ptr;
        ptr_next      = tbuf_ptr;
        req_next.valid = 1'b0;
        req_next.kind  = raster_mem_pkg::TILE_FETCH;
        req_next.mask  = '0;
        req_next.addr  = '0;
        if (start_ok || (rsp_data && last_prim && !last_tile)) begin
            req_next.valid   = 1'b1;
            req_next.mask    = raster_mem_pkg::TILE_MASK;
            req_next.addr[0] = tile_base;
            req_next.addr[1] = tile_base + DW'(raster_mem_pkg::WORD_BYTES);
            ptr_next         = tile_base + DW'(2 * raster_mem_pkg::WORD_BYTES);
        end else if (want_id && rs_free) begin
            req_next.valid   = 1'b1;
            req_next.kind    = raster_mem_pkg::PRIM_ID_FETCH;
            req_next.mask    = raster_mem_pkg::PRIM_ID_MASK;
            req_next.addr[0] = tbuf_ptr;
            ptr_next         = tbuf_ptr + DW'(raster_mem_pkg::WORD_BYTES);
        end else if (addr_valid) begin
            req_next.valid = 1'b1;
            req_next.kind  = raster_mem_pkg::PRIM_DATA_FETCH;
            req_next.mask  = raster_mem_pkg::PRIM_DATA_MASK;
            req_next.addr  = edge_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_req.valid <= 1'b0;
        end else begin
            mem_req <= req_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            id_pending <= 1'b0;
            tile_count <= '0;
            prim_count <= '0;
        end else begin
            id_pending <= want_id && !rs_free;
            tbuf_ptr   <= ptr_next;
            if (start_ok) begin
                busy        <= 1'b1;
                num_tiles_q <= cfg.num_tiles;
                tile_count  <= '0;
                prim_count  <= '0;
            end
            if (rsp_tile) begin
                x_loc_q   <= DIM'(lane0.coord.col << TILE_BITS);
                y_loc_q   <= DIM'(lane0.coord.row << TILE_BITS);
                num_prims <= mem_rsp.data[1];
            end
            if (rsp_id) begin
                pid_q <= lane0.raw;
            end
            if (rsp_data) begin
                if (last_prim) begin
                    prim_count <= '0;
                    tile_count <= tile_count + 1'b1;
                    // Job ends with the last primitive of the last tile
                    if (last_tile) begin
                        busy <= 1'b0;
                    end
                end else begin
                    prim_count <= prim_count + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/raster_mem_pkg.sv ====
`default_nettype none

package raster_mem_pkg;

    parameter int DATA_BITS         = 32;
    parameter int DIM_BITS          = 16;
    parameter int NUM_LANES         = 9;
    parameter int WORD_BYTES        = 4;
    parameter int PRIM_ADDR_LATENCY = 3;

    // Kind of a memory request, returned unchanged with its response
    typedef enum logic [1:0] {
        TILE_FETCH      = 2'd1,
        PRIM_ID_FETCH   = 2'd2,
        PRIM_DATA_FETCH = 2'd3
    } fetch_kind_e;

    // Tile fetch reads the coordinate and count words
    localparam logic [NUM_LANES-1:0] TILE_MASK      = 9'b0_0000_0011;
    localparam logic [NUM_LANES-1:0] PRIM_ID_MASK   = 9'b0_0000_0001;
    localparam logic [NUM_LANES-1:0] PRIM_DATA_MASK = 9'b1_1111_1111;

    typedef logic signed [DATA_BITS-1:0] edge_word_t;

    typedef struct packed {
        logic [DATA_BITS-1:0] num_tiles;
        logic [DATA_BITS-1:0] tbuf_base;
        logic [DATA_BITS-1:0] pbuf_base;
        logic [DATA_BITS-1:0] pbuf_stride;
    } raster_cfg_t;

    typedef struct packed {
        logic                                 valid;
        fetch_kind_e                          kind;
        logic [NUM_LANES-1:0]                 mask;
        logic [NUM_LANES-1:0][DATA_BITS-1:0]  addr;
    } mem_req_t;

    typedef struct packed {
        logic                                 valid;
        fetch_kind_e                          kind;
        logic [NUM_LANES-1:0][DATA_BITS-1:0]  data;
    } mem_rsp_t;

    // Row index sits in the high half-word
    typedef struct packed {
        logic [DIM_BITS-1:0] row;
        logic [DIM_BITS-1:0] col;
    } tile_coord_t;

    // Lane 0 holds tile coordinates or a primitive id, depending on the kind
    typedef union packed {
        tile_coord_t          coord;
        logic [DATA_BITS-1:0] raw;
    } tile_word_u;

    typedef struct packed {
        logic [DIM_BITS-1:0]    x_loc;
        logic [DIM_BITS-1:0]    y_loc;
        edge_word_t [2:0][2:0]  edges;
        logic [DATA_BITS-1:0]   pid;
    } raster_packet_t;

endpackage

`default_nettype wire
